/* hw/qpu_cfg_pkg.sv */
package qpu_cfg_pkg;

  ////////////////////////////////////////////////////////////
  // timing
  ////////////////////////////////////////////////////////////

  // wait duration width, also the trigger counter width
  localparam int TIME_WIDTH = 16;

  ////////////////////////////////////////////////////////////
  // event outputs
  ////////////////////////////////////////////////////////////

  // number of output event channels
  localparam int EVENT_NUM = 4;
  // data driven on the event wires
  localparam int EVENT_WIRE_WIDTH = 8;

  ////////////////////////////////////////////////////////////
  // measurement feedback
  ////////////////////////////////////////////////////////////

  // qubits held in the result register
  localparam int QUBIT_NUM = 5;
  // qubit index carried by a conditional event
  localparam int QUBIT_IDX_WIDTH = 3;

  // entries per queue, equal to the host's initial credits
  localparam int QUEUE_DEPTH = 8;

endpackage

/* hw/qpu_types_pkg.sv */
package qpu_types_pkg;

  ////////////////////////////////////////////////////////////
  // condition attached to an event
  ////////////////////////////////////////////////////////////

  typedef enum logic [1:0] {
    // always issued
    COND_NONE    = 2'd0,
    // issued only if the tested qubit measured 0
    COND_IF_ZERO = 2'd1,
    // issued only if the tested qubit measured 1
    COND_IF_ONE  = 2'd2
  } cond_e;

  ////////////////////////////////////////////////////////////
  // queue entries
  ////////////////////////////////////////////////////////////

  // one time point, in trigger cycles
  typedef struct packed {
    logic [qpu_cfg_pkg::TIME_WIDTH-1:0] wait_cycles;
  } time_entry_t;

  // one event, 17 bits with the default sizes
  typedef struct packed {
    logic [qpu_cfg_pkg::EVENT_NUM-1:0]        mask;
    logic [qpu_cfg_pkg::EVENT_WIRE_WIDTH-1:0] data;
    cond_e                                    cond;
    logic [qpu_cfg_pkg::QUBIT_IDX_WIDTH-1:0]  qubit;
  } event_entry_t;

  ////////////////////////////////////////////////////////////
  // measurement unit and output side
  ////////////////////////////////////////////////////////////

  // result write, only masked qubits are touched
  typedef struct packed {
    logic [qpu_cfg_pkg::QUBIT_NUM-1:0] mask;
    logic [qpu_cfg_pkg::QUBIT_NUM-1:0] result;
  } meas_wr_t;

  // issued event, one valid bit per channel
  typedef struct packed {
    logic [qpu_cfg_pkg::EVENT_NUM-1:0]        valid;
    logic [qpu_cfg_pkg::EVENT_WIRE_WIDTH-1:0] data;
  } event_out_t;

endpackage

/* hw/qpu_credit_fifo.sv */
`timescale 1ns/1ps

module qpu_credit_fifo #(
  parameter type T_PAYLOAD = logic,
  parameter int  DEPTH     = 8
) (
  input  logic     clk,
  input  logic     i_arst_n,
  input  logic     i_push,
  input  T_PAYLOAD i_data,
  input  logic     i_pop,
  output T_PAYLOAD o_head,
  output logic     o_nonempty,
  output logic     o_credit
);

  // storage, no reset on payload
  T_PAYLOAD mem [DEPTH];

  logic [$clog2(DEPTH)-1:0]   wr_ptr;
  logic [$clog2(DEPTH)-1:0]   rd_ptr;
  // occupancy, 0 up to DEPTH
  logic [$clog2(DEPTH+1)-1:0] count;
  logic                       full;
  logic                       do_push;
  logic                       do_pop;
  logic                       credit_q;

  ////////////////////////////////////////////////////////////
  // flags and qualified strobes
  ////////////////////////////////////////////////////////////

  assign full       = (count == ($clog2(DEPTH+1))'(DEPTH));
  assign o_nonempty = (count != '0);
  // pop on empty is ignored
  assign do_pop     = i_pop && o_nonempty;
  // push on full only lands if a slot frees in the same cycle
  assign do_push    = i_push && (!full || do_pop);

  ////////////////////////////////////////////////////////////
  // write side
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk)
  begin
    if (do_push)
    begin
      mem[wr_ptr] <= i_data;
    end
  end

  // pointers and occupancy
  always_ff @(posedge clk or negedge i_arst_n)
  begin
    if (!i_arst_n)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      // explicit wrap, DEPTH need not be a power of two
      if (do_push)
      begin
        wr_ptr <= (wr_ptr == ($clog2(DEPTH))'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (do_pop)
      begin
        rd_ptr <= (rd_ptr == ($clog2(DEPTH))'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  ////////////////////////////////////////////////////////////
  // read side and credit return
  ////////////////////////////////////////////////////////////

  // head visible the cycle after its push
  assign o_head = mem[rd_ptr];

  // one credit back per pop, one cycle later
  always_ff @(posedge clk or negedge i_arst_n)
  begin
    if (!i_arst_n)
    begin
      credit_q <= 1'b0;
    end
    else
    begin
      credit_q <= do_pop;
    end
  end

  assign o_credit = credit_q;

endmodule

/* hw/qpu_meas_reg.sv */
`timescale 1ns/1ps

module qpu_meas_reg (
  input  logic                               clk,
  input  logic                               i_arst_n,
  input  logic                               i_meas_wen,
  input  qpu_types_pkg::meas_wr_t            i_meas_wr,
  output logic [qpu_cfg_pkg::QUBIT_NUM-1:0]  o_meas_zero,
  output logic [qpu_cfg_pkg::QUBIT_NUM-1:0]  o_meas_one
);

  // last result per qubit
  logic [qpu_cfg_pkg::QUBIT_NUM-1:0] result_q;
  // qubit measured at least once since reset
  logic [qpu_cfg_pkg::QUBIT_NUM-1:0] known_q;

  ////////////////////////////////////////////////////////////
  // result bits, only masked qubits change
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk)
  begin
    if (i_meas_wen)
    begin
      result_q <= (result_q & ~i_meas_wr.mask) | (i_meas_wr.result & i_meas_wr.mask);
    end
  end

  // known bits, cleared by reset
  always_ff @(posedge clk or negedge i_arst_n)
  begin
    if (!i_arst_n)
    begin
      known_q <= '0;
    end
    else if (i_meas_wen)
    begin
      known_q <= known_q | i_meas_wr.mask;
    end
  end

  ////////////////////////////////////////////////////////////
  // feedback flags
  ////////////////////////////////////////////////////////////

  // unknown qubit raises neither flag
  assign o_meas_zero = known_q & ~result_q;
  assign o_meas_one  = known_q & result_q;

endmodule

/* hw/qpu_timing_ctrl.sv */
`timescale 1ns/1ps

module qpu_timing_ctrl (
  input  logic                              clk,
  input  logic                              i_arst_n,
  input  logic                              i_trigger,
  input  qpu_types_pkg::time_entry_t        i_tp_head,
  input  logic                              i_tp_nonempty,
  input  qpu_types_pkg::event_entry_t       i_ev_head,
  input  logic                              i_ev_nonempty,
  input  logic [qpu_cfg_pkg::QUBIT_NUM-1:0] i_meas_zero,
  input  logic [qpu_cfg_pkg::QUBIT_NUM-1:0] i_meas_one,
  output logic                              o_pop,
  output qpu_types_pkg::event_out_t         o_event
);

  // trigger cycles already spent on the head time point
  logic [qpu_cfg_pkg::TIME_WIDTH-1:0]             cnt_q;
  logic [qpu_cfg_pkg::TIME_WIDTH-1:0]             target;
  logic                                           count_en;
  logic                                           release_now;
  // flags widened to the full index range
  logic [2**qpu_cfg_pkg::QUBIT_IDX_WIDTH-1:0]     zero_ext;
  logic [2**qpu_cfg_pkg::QUBIT_IDX_WIDTH-1:0]     one_ext;
  logic                                           cond_pass;
  logic                                           issue;
  logic [qpu_cfg_pkg::EVENT_NUM-1:0]              valid_q;
  logic [qpu_cfg_pkg::EVENT_WIRE_WIDTH-1:0]       data_q;

  ////////////////////////////////////////////////////////////
  // trigger-cycle counter
  ////////////////////////////////////////////////////////////

  // empty queue stalls the count
  assign count_en = i_trigger && i_tp_nonempty && i_ev_nonempty;
  // wait of 0 behaves as 1
  assign target = (i_tp_head.wait_cycles == '0) ?
                  (qpu_cfg_pkg::TIME_WIDTH)'(1) : i_tp_head.wait_cycles;
  // this counting cycle is number cnt_q + 1
  assign release_now = count_en && ((cnt_q + 1'b1) == target);
  // pops time point and event together
  assign o_pop = release_now;

  always_ff @(posedge clk or negedge i_arst_n)
  begin
    if (!i_arst_n)
    begin
      cnt_q <= '0;
    end
    else if (release_now)
    begin
      cnt_q <= '0;
    end
    else if (count_en)
    begin
      cnt_q <= cnt_q + 1'b1;
    end
  end

  ////////////////////////////////////////////////////////////
  // condition check on the head event
  ////////////////////////////////////////////////////////////

  // indices past QUBIT_NUM read as unmeasured
  assign zero_ext = (2**qpu_cfg_pkg::QUBIT_IDX_WIDTH)'(i_meas_zero);
  assign one_ext  = (2**qpu_cfg_pkg::QUBIT_IDX_WIDTH)'(i_meas_one);

  always_comb
  begin
    case (i_ev_head.cond)
      qpu_types_pkg::COND_NONE:    cond_pass = 1'b1;
      qpu_types_pkg::COND_IF_ZERO: cond_pass = zero_ext[i_ev_head.qubit];
      qpu_types_pkg::COND_IF_ONE:  cond_pass = one_ext[i_ev_head.qubit];
      default:                     cond_pass = 1'b0;
    endcase
  end

  // failed condition drops the event but still pops it
  assign issue = release_now && cond_pass;

  ////////////////////////////////////////////////////////////
  // registered event output, one-cycle pulse
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge i_arst_n)
  begin
    if (!i_arst_n)
    begin
      valid_q <= '0;
    end
    else
    begin
      valid_q <= issue ? i_ev_head.mask : '0;
    end
  end

  // wires idle at zero between pulses
  always_ff @(posedge clk)
  begin
    data_q <= issue ? i_ev_head.data : '0;
  end

  assign o_event = '{valid: valid_q, data: data_q};

endmodule

/* hw/qpu_queue_top.sv */
`timescale 1ns/1ps

module qpu_queue_top (
  input  logic                        clk,
  input  logic                        i_arst_n,
  input  logic                        i_trigger,
  // time-point push, credit based
  input  logic                        i_tp_push,
  input  qpu_types_pkg::time_entry_t  i_tp_entry,
  output logic                        o_tp_credit,
  // event push, credit based
  input  logic                        i_ev_push,
  input  qpu_types_pkg::event_entry_t i_ev_entry,
  output logic                        o_ev_credit,
  // measurement unit write
  input  logic                        i_meas_wen,
  input  qpu_types_pkg::meas_wr_t     i_meas_wr,
  output qpu_types_pkg::event_out_t   o_event
);

  ////////////////////////////////////////////////////////////
  // internal nets
  ////////////////////////////////////////////////////////////

  qpu_types_pkg::time_entry_t        tp_head;
  logic                              tp_nonempty;
  qpu_types_pkg::event_entry_t       ev_head;
  logic                              ev_nonempty;
  // shared release strobe
  logic                              pop;
  logic [qpu_cfg_pkg::QUBIT_NUM-1:0] meas_zero;
  logic [qpu_cfg_pkg::QUBIT_NUM-1:0] meas_one;

  // time-point queue
  qpu_credit_fifo #(
    .T_PAYLOAD (qpu_types_pkg::time_entry_t),
    .DEPTH     (qpu_cfg_pkg::QUEUE_DEPTH)
  ) u_tp_fifo (
    .clk        (clk),
    .i_arst_n   (i_arst_n),
    .i_push     (i_tp_push),
    .i_data     (i_tp_entry),
    .i_pop      (pop),
    .o_head     (tp_head),
    .o_nonempty (tp_nonempty),
    .o_credit   (o_tp_credit)
  );

  // event queue
  qpu_credit_fifo #(
    .T_PAYLOAD (qpu_types_pkg::event_entry_t),
    .DEPTH     (qpu_cfg_pkg::QUEUE_DEPTH)
  ) u_ev_fifo (
    .clk        (clk),
    .i_arst_n   (i_arst_n),
    .i_push     (i_ev_push),
    .i_data     (i_ev_entry),
    .i_pop      (pop),
    .o_head     (ev_head),
    .o_nonempty (ev_nonempty),
    .o_credit   (o_ev_credit)
  );

  // fast feedback flags
  qpu_meas_reg u_meas_reg (
    .clk         (clk),
    .i_arst_n    (i_arst_n),
    .i_meas_wen  (i_meas_wen),
    .i_meas_wr   (i_meas_wr),
    .o_meas_zero (meas_zero),
    .o_meas_one  (meas_one)
  );

  qpu_timing_ctrl u_timing_ctrl (
    .clk           (clk),
    .i_arst_n      (i_arst_n),
    .i_trigger     (i_trigger),
    .i_tp_head     (tp_head),
    .i_tp_nonempty (tp_nonempty),
    .i_ev_head     (ev_head),
    .i_ev_nonempty (ev_nonempty),
    .i_meas_zero   (meas_zero),
    .i_meas_one    (meas_one),
    .o_pop         (pop),
    .o_event       (o_event)
  );

endmodule

/* testbench/qpu_queue_chk.sv */
`timescale 1ns/1ps

module qpu_queue_chk (
  input  logic                      clk,
  input  logic                      i_arst_n,
  input  logic                      i_tp_push,
  input  logic                      i_ev_push,
  input  logic                      i_tp_credit,
  input  logic                      i_ev_credit,
  input  qpu_types_pkg::event_out_t i_event
);

  // host credits as seen at the DUT ports
  int tp_cred;
  int ev_cred;
  // failed assertions, read by the testbench at the end
  int fail_count = 0;

  always_ff @(posedge clk or negedge i_arst_n)
  begin
    if (!i_arst_n)
    begin
      tp_cred <= qpu_cfg_pkg::QUEUE_DEPTH;
      ev_cred <= qpu_cfg_pkg::QUEUE_DEPTH;
    end
    else
    begin
      tp_cred <= tp_cred - int'(i_tp_push) + int'(i_tp_credit);
      ev_cred <= ev_cred - int'(i_ev_push) + int'(i_ev_credit);
    end
  end

  ////////////////////////////////////////////////////////////
  // occupancy, a push needs a credit
  ////////////////////////////////////////////////////////////

  a_tp_overflow: assert property (@(posedge clk) disable iff (!i_arst_n)
    i_tp_push |-> (tp_cred > 0))
    else begin fail_count++; $error("time-point push without a credit"); end

  a_ev_overflow: assert property (@(posedge clk) disable iff (!i_arst_n)
    i_ev_push |-> (ev_cred > 0))
    else begin fail_count++; $error("event push without a credit"); end

  // more credits than entries means a spurious credit pulse
  a_credit_range: assert property (@(posedge clk) disable iff (!i_arst_n)
    (tp_cred <= qpu_cfg_pkg::QUEUE_DEPTH) && (ev_cred <= qpu_cfg_pkg::QUEUE_DEPTH))
    else begin fail_count++; $error("credit returned without a pop"); end

  ////////////////////////////////////////////////////////////
  // output hygiene
  ////////////////////////////////////////////////////////////

  a_valid_known: assert property (@(posedge clk) disable iff (!i_arst_n)
    !$isunknown({i_event.valid, i_tp_credit, i_ev_credit}))
    else begin fail_count++; $error("event valid or credit output is unknown"); end

endmodule

bind qpu_queue_top qpu_queue_chk u_chk (
  .clk         (clk),
  .i_arst_n    (i_arst_n),
  .i_tp_push   (i_tp_push),
  .i_ev_push   (i_ev_push),
  .i_tp_credit (o_tp_credit),
  .i_ev_credit (o_ev_credit),
  .i_event     (o_event)
);

/* testbench/qpu_queue_monitor.sv */
`timescale 1ns/1ps

module qpu_queue_monitor (
  input  logic                               clk,
  input  logic                               i_arst_n,
  input  logic                               i_trigger,
  input  logic                               i_tp_push,
  input  logic                               i_ev_push,
  input  logic                               i_tp_credit,
  input  logic                               i_ev_credit,
  input  qpu_types_pkg::event_out_t          i_event,
  // expected side, from the pattern reader
  input  logic                               i_exp_push,
  input  qpu_types_pkg::event_out_t          i_exp_event,
  input  logic [qpu_cfg_pkg::TIME_WIDTH-1:0] i_exp_gap,
  input  logic                               i_drop_push,
  input  logic                               i_test_end,
  output int                                 o_test_count,
  output int                                 o_error_count
);

  qpu_types_pkg::event_out_t exp_q [$];
  int                        gap_q [$];
  int                        tests_done = 0;
  int                        errors = 0;
  // per-test tallies
  int                        test_errors = 0;
  int                        tp_pushes = 0;
  int                        ev_pushes = 0;
  int                        tp_credits = 0;
  int                        ev_credits = 0;
  int                        outputs = 0;
  int                        drops = 0;
  // cycles since the last output pulse
  int                        since_last = 1000;
  // trigger during the release cycle
  logic                      trig_q = 1'b0;

  assign o_test_count  = tests_done;
  assign o_error_count = errors;

  task automatic count_error(input string msg);
    begin
      $display("%s", msg);
      errors++;
      test_errors++;
    end
  endtask

  ////////////////////////////////////////////////////////////
  // compare one output pulse
  ////////////////////////////////////////////////////////////

  task automatic check_output();
    qpu_types_pkg::event_out_t exp;
    int                        gap;
    begin
      if (!trig_q)
        count_error("event issued while the trigger was low");
      if (exp_q.size() == 0)
      begin
        count_error("event issued while none was expected");
      end
      else
      begin
        exp = exp_q.pop_front();
        gap = gap_q.pop_front();
        if (i_event !== exp)
          count_error($sformatf("** Error: o_event expected 0x%h got 0x%h", exp, i_event));
        // spacing is never below the later event's wait
        if (since_last < gap)
          count_error($sformatf("event came %0d cycles after the previous one, wait is %0d",
                                since_last, gap));
      end
      outputs++;
      since_last = 0;
    end
  endtask

  // credits and drops, then one line for the test
  task automatic close_test();
    begin
      tests_done++;
      if (exp_q.size() != 0)
        count_error($sformatf("%0d expected events never came out", exp_q.size()));
      if (tp_credits != tp_pushes)
        count_error($sformatf("** Error: o_tp_credit pulses expected 0x%h got 0x%h",
                              tp_pushes, tp_credits));
      if (ev_credits != ev_pushes)
        count_error($sformatf("** Error: o_ev_credit pulses expected 0x%h got 0x%h",
                              ev_pushes, ev_credits));
      if (ev_credits - outputs != drops)
        count_error($sformatf("%0d events dropped where %0d drops were expected",
                              ev_credits - outputs, drops));
      $display("test %0d %s: %0d events out, %0d dropped, %0d errors", tests_done,
               (test_errors == 0) ? "ok" : "failed", outputs, ev_credits - outputs, test_errors);
      exp_q.delete();
      gap_q.delete();
      test_errors = 0;
      tp_pushes   = 0;
      ev_pushes   = 0;
      tp_credits  = 0;
      ev_credits  = 0;
      outputs     = 0;
      drops       = 0;
    end
  endtask

  ////////////////////////////////////////////////////////////
  // sampled on the rising edge, all inputs settled
  ////////////////////////////////////////////////////////////

  always @(posedge clk)
  begin
    if (!i_arst_n)
    begin
      if ((i_event.valid != '0) || i_tp_credit || i_ev_credit)
        count_error("output active while reset is asserted");
    end
    else
    begin
      // expected entries land before any output compare
      if (i_exp_push)
      begin
        exp_q.push_back(i_exp_event);
        gap_q.push_back(int'(i_exp_gap));
      end
      drops      += int'(i_drop_push);
      tp_pushes  += int'(i_tp_push);
      ev_pushes  += int'(i_ev_push);
      tp_credits += int'(i_tp_credit);
      ev_credits += int'(i_ev_credit);
      since_last++;
      if (i_event.valid != '0)
        check_output();
      if (i_test_end)
        close_test();
    end
    trig_q <= i_trigger;
  end

endmodule

/* testbench/tb_qpu_queue.sv */
`timescale 1ns/1ps

module tb_qpu_queue;

  logic                               clk;
  logic                               i_arst_n;
  logic                               i_trigger;
  logic                               i_tp_push;
  qpu_types_pkg::time_entry_t         i_tp_entry;
  logic                               o_tp_credit;
  logic                               i_ev_push;
  qpu_types_pkg::event_entry_t        i_ev_entry;
  logic                               o_ev_credit;
  logic                               i_meas_wen;
  qpu_types_pkg::meas_wr_t            i_meas_wr;
  qpu_types_pkg::event_out_t          o_event;
  // expected records toward the monitor
  logic                               exp_push;
  qpu_types_pkg::event_out_t          exp_event;
  logic [qpu_cfg_pkg::TIME_WIDTH-1:0] exp_gap;
  logic                               drop_push;
  logic                               test_end;
  int                                 test_count;
  int                                 error_count;
  // host credits, one per free queue slot
  int                                 tp_credits;
  int                                 ev_credits;
  // timeouts and file trouble
  int                                 fails;

  initial clk = 1'b0;
  always #50 clk = ~clk;

  qpu_queue_top UUT (
    .clk         (clk),
    .i_arst_n    (i_arst_n),
    .i_trigger   (i_trigger),
    .i_tp_push   (i_tp_push),
    .i_tp_entry  (i_tp_entry),
    .o_tp_credit (o_tp_credit),
    .i_ev_push   (i_ev_push),
    .i_ev_entry  (i_ev_entry),
    .o_ev_credit (o_ev_credit),
    .i_meas_wen  (i_meas_wen),
    .i_meas_wr   (i_meas_wr),
    .o_event     (o_event)
  );

  qpu_queue_monitor u_monitor (
    .clk           (clk),
    .i_arst_n      (i_arst_n),
    .i_trigger     (i_trigger),
    .i_tp_push     (i_tp_push),
    .i_ev_push     (i_ev_push),
    .i_tp_credit   (o_tp_credit),
    .i_ev_credit   (o_ev_credit),
    .i_event       (o_event),
    .i_exp_push    (exp_push),
    .i_exp_event   (exp_event),
    .i_exp_gap     (exp_gap),
    .i_drop_push   (drop_push),
    .i_test_end    (test_end),
    .o_test_count  (test_count),
    .o_error_count (error_count)
  );

  // credit pulses counted mid-cycle, away from the push edge
  always @(negedge clk)
  begin
    if (i_arst_n && o_tp_credit)
      tp_credits = tp_credits + 1;
    if (i_arst_n && o_ev_credit)
      ev_credits = ev_credits + 1;
  end

  ////////////////////////////////////////////////////////////
  // stimulus helpers, strobes last one cycle
  ////////////////////////////////////////////////////////////

  task automatic next_cycle();
    begin
      @(posedge clk);
      i_tp_push  <= 1'b0;
      i_ev_push  <= 1'b0;
      i_meas_wen <= 1'b0;
      exp_push   <= 1'b0;
      drop_push  <= 1'b0;
      test_end   <= 1'b0;
    end
  endtask

  task automatic push_pair(input logic [31:0] wait_v, mask, data, cond, qubit);
    int waited;
    begin
      waited = 0;
      next_cycle();
      while ((tp_credits == 0 || ev_credits == 0) && waited < 1000)
      begin
        next_cycle();
        waited++;
      end
      if (tp_credits == 0 || ev_credits == 0)
      begin
        $display("timeout: no credit came back for a push");
        fails++;
      end
      else
      begin
        i_tp_push              <= 1'b1;
        i_tp_entry.wait_cycles <= wait_v[qpu_cfg_pkg::TIME_WIDTH-1:0];
        i_ev_push              <= 1'b1;
        i_ev_entry.mask        <= mask[qpu_cfg_pkg::EVENT_NUM-1:0];
        i_ev_entry.data        <= data[qpu_cfg_pkg::EVENT_WIRE_WIDTH-1:0];
        i_ev_entry.cond        <= qpu_types_pkg::cond_e'(cond[1:0]);
        i_ev_entry.qubit       <= qubit[qpu_cfg_pkg::QUBIT_IDX_WIDTH-1:0];
        tp_credits--;
        ev_credits--;
      end
    end
  endtask

  // test ends once every credit is back
  task automatic wait_drain();
    int waited;
    begin
      waited = 0;
      next_cycle();
      while (!(tp_credits == qpu_cfg_pkg::QUEUE_DEPTH && ev_credits == qpu_cfg_pkg::QUEUE_DEPTH)
             && waited < 1000)
      begin
        next_cycle();
        waited++;
      end
      if (tp_credits != qpu_cfg_pkg::QUEUE_DEPTH || ev_credits != qpu_cfg_pkg::QUEUE_DEPTH)
      begin
        $display("timeout: queues did not drain");
        fails++;
      end
      else
      begin
        test_end <= 1'b1;
      end
    end
  endtask

  task automatic apply_record(input logic [31:0] op, a, b, c, d, e);
    begin
      case (op)
        1: push_pair(a, b, c, d, e);
        2:
        begin
          next_cycle();
          i_meas_wen       <= 1'b1;
          i_meas_wr.mask   <= a[qpu_cfg_pkg::QUBIT_NUM-1:0];
          i_meas_wr.result <= b[qpu_cfg_pkg::QUBIT_NUM-1:0];
        end
        3:
        begin
          next_cycle();
          i_trigger <= a[0];
        end
        4: repeat (a) next_cycle();
        5:
        begin
          next_cycle();
          exp_push        <= 1'b1;
          exp_event.valid <= a[qpu_cfg_pkg::EVENT_NUM-1:0];
          exp_event.data  <= b[qpu_cfg_pkg::EVENT_WIRE_WIDTH-1:0];
          exp_gap         <= c[qpu_cfg_pkg::TIME_WIDTH-1:0];
        end
        6:
        begin
          next_cycle();
          drop_push <= 1'b1;
        end
        7: wait_drain();
        default:
        begin
          $display("unknown record type %0h in the patterns file", op);
          fails++;
        end
      endcase
    end
  endtask

  ////////////////////////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////////////////////////

  initial
  begin
    int          fd;
    int          n;
    string       line;
    logic [31:0] op;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] c;
    logic [31:0] d;
    logic [31:0] e;
    i_arst_n   = 1'b0;
    i_trigger  = 1'b0;
    i_tp_push  = 1'b0;
    i_tp_entry = '0;
    i_ev_push  = 1'b0;
    i_ev_entry = '0;
    i_meas_wen = 1'b0;
    i_meas_wr  = '0;
    exp_push   = 1'b0;
    exp_event  = '0;
    exp_gap    = '0;
    drop_push  = 1'b0;
    test_end   = 1'b0;
    tp_credits = qpu_cfg_pkg::QUEUE_DEPTH;
    ev_credits = qpu_cfg_pkg::QUEUE_DEPTH;
    fails      = 0;
    repeat (2) @(posedge clk);
    i_arst_n <= 1'b1;
    fd = $fopen("testbench/qpu_queue_patterns.txt", "r");
    if (fd == 0)
    begin
      $display("could not open the patterns file");
      fails++;
    end
    else
    begin
      // comment lines fail the scan and are skipped
      while (!$feof(fd) && fails == 0)
      begin
        n = $fgets(line, fd);
        if (n > 0 && $sscanf(line, "%h %h %h %h %h %h", op, a, b, c, d, e) == 6)
          apply_record(op, a, b, c, d, e);
      end
      $fclose(fd);
    end
    // monitor closes the last test one edge later
    repeat (2) next_cycle();
    $display("%0d tests run, %0d errors", test_count,
             error_count + fails + UUT.u_chk.fail_count);
    if (fails == 0 && error_count == 0 && UUT.u_chk.fail_count == 0 && test_count > 0)
    begin
      $display("*** TEST PASSED ***");
    end
    else
    begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

/* testbench/qpu_queue_patterns.txt */
# op a b c d e in hex; 1 push: wait mask data cond qubit; 2 meas write: mask result
# 3 trigger: level; 4 idle: cycles; 5 expect: mask data min_gap; 6 expect drop; 7 end of test
# unconditional order and spacing
5 1 a5 3 0 0
5 2 3c 1 0 0
5 c 81 1 0 0
5 3 5a 5 0 0
1 3 1 a5 0 0
1 1 2 3c 0 0
1 0 c 81 0 0
1 5 3 5a 0 0
3 1 0 0 0 0
7 0 0 0 0 0
# trigger pause in the middle of a wait
3 0 0 0 0 0
5 4 c3 3 0 0
5 8 3e 4 0 0
1 3 4 c3 0 0
1 4 8 3e 0 0
3 1 0 0 0 0
4 5 0 0 0 0
3 0 0 0 0 0
4 8 0 0 0 0
3 1 0 0 0 0
7 0 0 0 0 0
# measurement feedback, qubit 2 reads 1, qubit 0 reads 0
2 5 4 0 0 0
5 1 11 2 0 0
6 0 0 0 0 0
6 0 0 0 0 0
6 0 0 0 0 0
5 8 55 2 0 0
1 2 1 11 2 2
1 2 2 22 1 2
1 2 4 33 2 4
1 2 2 44 1 3
1 2 8 55 1 0
7 0 0 0 0 0
# credit burst, both queues full then drained
3 0 0 0 0 0
5 1 10 1 0 0
5 2 11 1 0 0
5 4 12 1 0 0
5 8 13 1 0 0
5 3 14 1 0 0
5 6 15 1 0 0
5 c 16 1 0 0
5 f 17 1 0 0
1 0 1 10 0 0
1 1 2 11 0 0
1 0 4 12 0 0
1 1 8 13 0 0
1 0 3 14 0 0
1 1 6 15 0 0
1 0 c 16 0 0
1 1 f 17 0 0
3 1 0 0 0 0
7 0 0 0 0 0

/* sim.f */
hw/qpu_cfg_pkg.sv
hw/qpu_types_pkg.sv
hw/qpu_credit_fifo.sv
hw/qpu_meas_reg.sv
hw/qpu_timing_ctrl.sv
hw/qpu_queue_top.sv
testbench/qpu_queue_chk.sv
testbench/qpu_queue_monitor.sv
testbench/tb_qpu_queue.sv

/* Bender.yml */
package:
  name: qpu_queue

sources:
  - hw/qpu_cfg_pkg.sv
  - hw/qpu_types_pkg.sv
  - hw/qpu_credit_fifo.sv
  - hw/qpu_meas_reg.sv
  - hw/qpu_timing_ctrl.sv
  - hw/qpu_queue_top.sv
  - target: test
    files:
      - testbench/qpu_queue_chk.sv
      - testbench/qpu_queue_monitor.sv
      - testbench/tb_qpu_queue.sv
